//--- common/cache_pkg.sv
package cache_pkg;

	// ====================
	// cache geometry
	// ====================

	localparam int ADDR_W     = 32;
	localparam int LINE_BYTES = 8;
	localparam int LINE_W     = LINE_BYTES * 8;
	localparam int OFFSET_W   = $clog2(LINE_BYTES);
	localparam int SETS       = 16;
	localparam int INDEX_W    = $clog2(SETS);
	// whatever is left above index and offset becomes the tag
	localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
	localparam int WAYS       = 4;
	localparam int WAY_W      = $clog2(WAYS);
	localparam int NUM_CH     = 2;

	// line writer sequencer states
	localparam logic [1:0] LW_IDLE  = 2'd0;
	localparam logic [1:0] LW_READ  = 2'd1;
	localparam logic [1:0] LW_MERGE = 2'd2;
	localparam logic [1:0] LW_WRITE = 2'd3;

	// ====================
	// address and storage
	// ====================

	typedef struct packed {
		logic [TAG_W-1:0]    tag;
		logic [INDEX_W-1:0]  index;
		logic [OFFSET_W-1:0] offset;
	} addr_fields_t;

	// the same address seen as a bus word or split for the lookup
	typedef union packed {
		logic [ADDR_W-1:0] word;
		addr_fields_t      f;
	} cache_addr_u;

	typedef struct packed {
		logic [TAG_W-1:0]  tag;
		logic [LINE_W-1:0] data;
	} way_entry_t;

	// one RAM word carries every way of a set with way 0 in the low bits
	typedef way_entry_t [WAYS-1:0] set_word_t;

	typedef logic [SETS-1:0][WAYS-1:0] valid_map_t;

	// write side shared by all set RAM copies
	typedef struct packed {
		logic               en;
		logic [INDEX_W-1:0] index;
		set_word_t          data;
	} ram_write_t;

	// ====================
	// port bundles
	// ====================

	typedef struct packed {
		logic        valid;
		cache_addr_u addr;
	} rd_req_t;

	typedef struct packed {
		logic              ack;
		logic [LINE_W-1:0] data;
	} rd_resp_t;

	// inv turns the write into an invalidate of the line it hits
	typedef struct packed {
		logic                  valid;
		cache_addr_u           addr;
		logic [LINE_W-1:0]     data;
		logic [LINE_BYTES-1:0] sel;
		logic                  inv;
	} wr_req_t;

	typedef struct packed {
		logic              valid;
		cache_addr_u       addr;
		logic [LINE_W-1:0] data;
	} fill_req_t;

	typedef struct packed {
		logic        valid;
		cache_addr_u addr;
	} miss_req_t;

endpackage

//--- design/lookup/set_ram.sv
`timescale 1ns/1ns

module set_ram import cache_pkg::*; (
	input  logic               wclk,
	input  ram_write_t         wr,
	input  logic               rd_en,
	input  logic [INDEX_W-1:0] rd_index,
	output set_word_t          rd_data
);

	// every way of a set sits in one word so a single read returns the whole set
	set_word_t mem [SETS];

	// the line writer owns the write side of every copy
	always_ff @(posedge wclk) begin
		if (wr.en) begin
			mem[wr.index] <= wr.data;
		end
	end

	// registered read with one cycle of latency
	// a read that meets a write to the same set returns the old word
	always_ff @(posedge wclk) begin
		if (rd_en) begin
			rd_data <= mem[rd_index];
		end
	end

endmodule

//--- design/lookup/tag_compare.sv
`timescale 1ns/1ns

module tag_compare import cache_pkg::*; (
	input  logic        wclk,
	input  logic        rst,
	input  rd_req_t     req,
	output rd_resp_t    resp,
	input  ram_write_t  ram_wr,
	input  valid_map_t  valid_map,
	output logic        miss,
	output cache_addr_u miss_addr
);

	set_word_t         rd_word;
	logic              s1_valid;
	logic              s1_stale;
	cache_addr_u       s1_addr;
	logic [WAYS-1:0]   s1_hit;
	logic [LINE_W-1:0] s1_line;
	logic              s2_valid;
	cache_addr_u       s2_addr;
	logic [WAYS-1:0]   hit_q;
	logic [LINE_W-1:0] line_q;

	// private copy of the set RAM for this channel
	set_ram u_ram (
		.wclk     (wclk),
		.wr       (ram_wr),
		.rd_en    (req.valid),
		.rd_index (req.addr.f.index),
		.rd_data  (rd_word)
	);

	// ====================
	// stage 1
	// ====================

	// the held request is looked up again every cycle until ack
	// so a fill that lands while waiting turns the miss into a hit
	always_ff @(posedge wclk) begin
		if (rst) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= req.valid & ~resp.ack;
		end
		s1_addr <= req.addr;
		// a write to this set on the read edge means the word read out is already old
		s1_stale <= ram_wr.en && (ram_wr.index == req.addr.f.index);
	end

	// compare all ways at once and keep the data of the lowest hitting way
	always_comb begin
		s1_line = '0;
		for (int w = WAYS - 1; w >= 0; w--) begin
			s1_hit[w] = valid_map[s1_addr.f.index][w] && (rd_word[w].tag == s1_addr.f.tag);
			if (s1_hit[w]) begin
				s1_line = rd_word[w].data;
			end
		end
	end

	// ====================
	// stage 2
	// ====================

	// stale lookups are dropped and the next pass picks up the new word
	always_ff @(posedge wclk) begin
		if (rst) begin
			s2_valid <= 1'b0;
		end else begin
			s2_valid <= s1_valid & ~s1_stale & ~resp.ack;
		end
		s2_addr <= s1_addr;
		hit_q   <= s1_hit;
		line_q  <= s1_line;
	end

	// ack clears both stages so it lasts exactly one cycle
	assign resp.ack  = s2_valid & (|hit_q);
	assign resp.data = line_q;

	// miss stays up while the request waits; the arbiter filters repeats
	assign miss      = s2_valid & ~(|hit_q);
	assign miss_addr = s2_addr;

	// the request must have been held unchanged through the whole lookup
	a_ack_held: assert property (@(posedge wclk) disable iff (rst)
		resp.ack |-> req.valid && $past(req.valid) && $past(req.valid, 2)
			&& ($past(req.addr, 2) == req.addr));

endmodule

//--- design/miss_arbiter.sv
`timescale 1ns/1ns

module miss_arbiter import cache_pkg::*; (
	input  logic                     wclk,
	input  logic                     rst,
	input  logic [NUM_CH-1:0]        miss,
	input  cache_addr_u [NUM_CH-1:0] miss_addr,
	input  logic [NUM_CH-1:0]        ack,
	output miss_req_t                req,
	input  logic                     ready
);

	logic [NUM_CH-1:0] outstanding;
	logic [NUM_CH-1:0] eligible;
	logic [NUM_CH-1:0] grant;
	cache_addr_u       pick_addr;
	logic              hold;
	logic              issue;

	// a channel with a miss already in flight is ignored until its ack
	assign eligible = miss & ~outstanding;

	// fixed priority with channel 0 on top
	// the loop walks downward so the lowest eligible channel is the last to write
	always_comb begin
		grant     = '0;
		pick_addr = miss_addr[0];
		for (int i = NUM_CH - 1; i >= 0; i--) begin
			if (eligible[i]) begin
				grant    = '0;
				grant[i] = 1'b1;
				pick_addr = miss_addr[i];
			end
		end
		// the memory side always returns a whole line
		pick_addr.f.offset = '0;
	end

	// a request not yet taken blocks any new one
	assign hold  = req.valid & ~ready;
	assign issue = ~hold & (|eligible);

	always_ff @(posedge wclk) begin
		if (rst) begin
			req.valid   <= 1'b0;
			outstanding <= '0;
		end else begin
			if (!hold) begin
				req.valid <= |eligible;
			end
			// a channel cannot miss and ack in the same cycle
			outstanding <= (outstanding | (issue ? grant : '0)) & ~ack;
		end
		if (issue) begin
			req.addr <= pick_addr;
		end
	end

	// back-pressure holds the request exactly as it was
	a_hold_stable: assert property (@(posedge wclk) disable iff (rst)
		req.valid && !ready |=> req.valid && $stable(req.addr));

endmodule

//--- design/line_writer.sv
`timescale 1ns/1ns

module line_writer import cache_pkg::*; (
	input  logic       wclk,
	input  logic       rst,
	input  fill_req_t  fill,
	output logic       fill_ready,
	input  wr_req_t    wr,
	output logic       wr_ready,
	output ram_write_t ram_wr,
	output valid_map_t valid_map
);

	logic [1:0]            state;
	logic                  fill_fire;
	logic                  wr_fire;
	logic                  op_fill;
	logic                  op_inv;
	cache_addr_u           op_addr;
	logic [LINE_W-1:0]     op_data;
	logic [LINE_BYTES-1:0] op_sel;
	set_word_t             rd_word;
	logic [WAYS-1:0]       set_valid;
	logic [WAYS-1:0]       hit;
	logic [WAY_W-1:0]      hit_way;
	set_word_t             merged;
	logic [WAYS-1:0]       merged_valid;
	set_word_t             word_q;
	logic [WAYS-1:0]       set_valid_q;
	logic                  ram_we_q;
	logic                  valid_we_q;
	valid_map_t            vmap;

	// ====================
	// handshake
	// ====================

	// one operation at a time and fill goes first when both are waiting
	assign fill_ready = (state == LW_IDLE);
	assign wr_ready   = (state == LW_IDLE) & ~fill.valid;
	assign fill_fire  = fill.valid & fill_ready;
	assign wr_fire    = wr.valid & wr_ready;

	// the accepted operation is held here for all three stages
	always_ff @(posedge wclk) begin
		if (fill_fire) begin
			op_fill <= 1'b1;
			op_inv  <= 1'b0;
			op_addr <= fill.addr;
			op_data <= fill.data;
			op_sel  <= '1;
		end else if (wr_fire) begin
			op_fill <= 1'b0;
			op_inv  <= wr.inv;
			op_addr <= wr.addr;
			op_data <= wr.data;
			op_sel  <= wr.sel;
		end
	end

	// read then merge then write and back to idle
	always_ff @(posedge wclk) begin
		if (rst) begin
			state <= LW_IDLE;
		end else begin
			case (state)
				LW_IDLE: begin
					if (fill_fire || wr_fire) begin
						state <= LW_READ;
					end
				end
				LW_READ:  state <= LW_MERGE;
				LW_MERGE: state <= LW_WRITE;
				default:  state <= LW_IDLE;
			endcase
		end
	end

	// own copy of the set RAM so the read never competes with a channel
	set_ram u_ram (
		.wclk     (wclk),
		.wr       (ram_wr),
		.rd_en    (state == LW_READ),
		.rd_index (op_addr.f.index),
		.rd_data  (rd_word)
	);

	// ====================
	// merge
	// ====================

	assign set_valid = vmap[op_addr.f.index];

	// lowest hitting way wins like on the read side
	always_comb begin
		hit_way = '0;
		for (int w = WAYS - 1; w >= 0; w--) begin
			hit[w] = set_valid[w] && (rd_word[w].tag == op_addr.f.tag);
			if (hit[w]) begin
				hit_way = WAY_W'(w);
			end
		end
	end

	always_comb begin
		merged       = rd_word;
		merged_valid = set_valid;
		if (op_fill) begin
			// new line enters way 0 and everything else moves down one way
			// whatever sat in the last way drops out
			merged[0].tag   = op_addr.f.tag;
			merged[0].data  = op_data;
			merged_valid[0] = 1'b1;
			for (int w = 1; w < WAYS; w++) begin
				merged[w]       = rd_word[w-1];
				merged_valid[w] = set_valid[w-1];
			end
		end else if (op_inv) begin
			merged_valid[hit_way] = 1'b0;
		end else begin
			for (int b = 0; b < LINE_BYTES; b++) begin
				if (op_sel[b]) begin
					merged[hit_way].data[b*8 +: 8] = op_data[b*8 +: 8];
				end
			end
		end
	end

	// a write or invalidate that misses leaves both enables low and changes nothing
	always_ff @(posedge wclk) begin
		if (state == LW_MERGE) begin
			word_q      <= merged;
			set_valid_q <= merged_valid;
			ram_we_q    <= op_fill | (~op_inv & (|hit));
			valid_we_q  <= op_fill | (op_inv & (|hit));
		end
	end

	// ====================
	// write
	// ====================

	assign ram_wr.en    = (state == LW_WRITE) & ram_we_q;
	assign ram_wr.index = op_addr.f.index;
	assign ram_wr.data  = word_q;

	// valid bits change on the same edge as the RAM words
	always_ff @(posedge wclk) begin
		if (rst) begin
			vmap <= '0;
		end else if ((state == LW_WRITE) && valid_we_q) begin
			vmap[op_addr.f.index] <= set_valid_q;
		end
	end

	assign valid_map = vmap;

	// only one port is taken per operation and nothing else is taken until it finishes
	a_one_op: assert property (@(posedge wclk) disable iff (rst)
		(fill_fire || wr_fire) |-> !(fill_fire && wr_fire)
			##1 !(fill_fire || wr_fire) ##1 !(fill_fire || wr_fire)
			##1 !(fill_fire || wr_fire));

endmodule

//--- design/cache_top.sv
`timescale 1ns/1ns

module cache_top import cache_pkg::*; (
	input  logic                  wclk,
	input  logic                  rst,
	input  rd_req_t [NUM_CH-1:0]  rd_req,
	output rd_resp_t [NUM_CH-1:0] rd_resp,
	input  wr_req_t               wr,
	output logic                  wr_ready,
	input  fill_req_t             fill,
	output logic                  fill_ready,
	output miss_req_t             miss,
	input  logic                  miss_ready
);

	// write side broadcast to every set RAM copy
	ram_write_t ram_wr;
	// valid bits live in the line writer and are read by every lookup
	valid_map_t valid_map;

	logic [NUM_CH-1:0]        ch_miss;
	cache_addr_u [NUM_CH-1:0] ch_miss_addr;
	logic [NUM_CH-1:0]        ch_ack;

	// ====================
	// read channels
	// ====================

	for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
		tag_compare u_lookup (
			.wclk      (wclk),
			.rst       (rst),
			.req       (rd_req[i]),
			.resp      (rd_resp[i]),
			.ram_wr    (ram_wr),
			.valid_map (valid_map),
			.miss      (ch_miss[i]),
			.miss_addr (ch_miss_addr[i])
		);

		// ack releases the channel's outstanding miss
		assign ch_ack[i] = rd_resp[i].ack;
	end

	// ====================
	// miss path and update
	// ====================

	miss_arbiter u_arb (
		.wclk      (wclk),
		.rst       (rst),
		.miss      (ch_miss),
		.miss_addr (ch_miss_addr),
		.ack       (ch_ack),
		.req       (miss),
		.ready     (miss_ready)
	);

	line_writer u_writer (
		.wclk       (wclk),
		.rst        (rst),
		.fill       (fill),
		.fill_ready (fill_ready),
		.wr         (wr),
		.wr_ready   (wr_ready),
		.ram_wr     (ram_wr),
		.valid_map  (valid_map)
	);

endmodule

//--- tb/tb_cache.sv
`timescale 1ns/1ns

module tb_cache import cache_pkg::*; ();

	localparam int NUM_OPS       = 400;
	localparam int CYCLES_PER_OP = 40;
	localparam int CYCLE_LIMIT   = NUM_OPS * CYCLES_PER_OP;

	logic                  wclk;
	logic                  rst;
	rd_req_t [NUM_CH-1:0]  rd_req;
	rd_resp_t [NUM_CH-1:0] rd_resp;
	wr_req_t               wr;
	logic                  wr_ready;
	fill_req_t             fill;
	logic                  fill_ready;
	miss_req_t             miss;
	logic                  miss_ready;

	// model of the cache contents with the newest line in way 0
	logic              m_valid [SETS][WAYS];
	logic [TAG_W-1:0]  m_tag [SETS][WAYS];
	logic [LINE_W-1:0] m_data [SETS][WAYS];

	// accepted misses waiting for their fill
	logic [ADDR_W-1:0] fq_addr [$];
	int                fq_due [$];

	logic [31:0]       seed;
	int                cyc;
	logic              fill_go;
	logic              wr_go;
	logic              miss_go;
	logic              held;
	logic [ADDR_W-1:0] held_addr;

	// state of the current read phase with one entry per channel
	logic              active [NUM_CH];
	logic              used [NUM_CH];
	logic              pred_hit [NUM_CH];
	logic              filled [NUM_CH];
	logic [ADDR_W-1:0] ph_addr [NUM_CH];
	logic              expect_nomiss;
	logic              check_prio;
	logic              first_seen;

	cache_top u_dut (
		.wclk       (wclk),
		.rst        (rst),
		.rd_req     (rd_req),
		.rd_resp    (rd_resp),
		.wr         (wr),
		.wr_ready   (wr_ready),
		.fill       (fill),
		.fill_ready (fill_ready),
		.miss       (miss),
		.miss_ready (miss_ready)
	);

	always #2 wclk = ~wclk;

	// ====================
	// helpers
	// ====================

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [ADDR_W-1:0] line_of(logic [ADDR_W-1:0] a);
		return {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
	endfunction

	// backing memory is a hash of the line address taken one byte at a time
	function automatic logic [LINE_W-1:0] backing_line(logic [ADDR_W-1:0] a);
		logic [LINE_W-1:0] d;
		logic [31:0]       h;
		h = line_of(a) * 32'h9e3779b1;
		for (int b = 0; b < LINE_BYTES; b++) begin
			d[b*8 +: 8] = h[7:0] ^ h[23:16] ^ 8'(b * 29);
			h = {h[26:0], h[31:27]} ^ 32'h5bd1e995;
		end
		return d;
	endfunction

	// lowest valid way with a matching tag or -1 when there is none
	function automatic int find_way(logic [ADDR_W-1:0] a);
		cache_addr_u ca;
		int          found;
		ca.word = a;
		found = -1;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (m_valid[ca.f.index][w] && (m_tag[ca.f.index][w] == ca.f.tag)) begin
				found = w;
			end
		end
		return found;
	endfunction

	task automatic model_fill(logic [ADDR_W-1:0] a, logic [LINE_W-1:0] d);
		cache_addr_u ca;
		ca.word = a;
		for (int w = WAYS - 1; w >= 1; w--) begin
			m_valid[ca.f.index][w] = m_valid[ca.f.index][w-1];
			m_tag[ca.f.index][w]   = m_tag[ca.f.index][w-1];
			m_data[ca.f.index][w]  = m_data[ca.f.index][w-1];
		end
		m_valid[ca.f.index][0] = 1'b1;
		m_tag[ca.f.index][0]   = ca.f.tag;
		m_data[ca.f.index][0]  = d;
	endtask

	// a write or invalidate to an absent line leaves the model alone
	task automatic model_write(wr_req_t q);
		int w;
		w = find_way(q.addr.word);
		if (w >= 0) begin
			if (q.inv) begin
				m_valid[q.addr.f.index][w] = 1'b0;
			end else begin
				for (int b = 0; b < LINE_BYTES; b++) begin
					if (q.sel[b]) begin
						m_data[q.addr.f.index][w][b*8 +: 8] = q.data[b*8 +: 8];
					end
				end
			end
		end
	endtask

	task automatic report_failure(string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	// small pool of lines in two sets so fills evict often
	function automatic logic [ADDR_W-1:0] pick_addr();
		logic [31:0] r;
		cache_addr_u ca;
		r = next_rand();
		ca.f.tag    = TAG_W'(25'h0a5 + (r[18:16] % 3'd6) * 25'h31);
		ca.f.index  = r[3] ? 4'd7 : 4'd2;
		ca.f.offset = r[6:4];
		return ca.word;
	endfunction

	// ====================
	// per-cycle checks
	// ====================

	task automatic check_miss();
		logic ok_line;
		if (held) begin
			assert (miss.valid && (miss.addr.word == held_addr)) else
				report_failure($sformatf("ERROR miss.addr got %h expected %h under back-pressure",
					miss.addr.word, held_addr));
		end else if (miss.valid) begin
			ok_line = 1'b0;
			for (int ch = 0; ch < NUM_CH; ch++) begin
				if (used[ch] && (line_of(ph_addr[ch]) == miss.addr.word)) begin
					ok_line = 1'b1;
				end
			end
			assert (miss.addr.f.offset == '0) else
				report_failure($sformatf("ERROR miss.addr got %h expected %h",
					miss.addr.word, line_of(miss.addr.word)));
			assert (!expect_nomiss) else
				report_failure("a miss request was raised although every read should hit");
			assert (ok_line) else
				report_failure("a miss request names a line that no channel reads");
			if (check_prio && !first_seen) begin
				assert (miss.addr.word == line_of(ph_addr[0])) else
					report_failure($sformatf("ERROR miss.addr got %h expected %h",
						miss.addr.word, line_of(ph_addr[0])));
			end
			first_seen = 1'b1;
		end
	endtask

	task automatic check_acks();
		int w;
		for (int ch = 0; ch < NUM_CH; ch++) begin
			if (rd_resp[ch].ack) begin
				assert (active[ch]) else
					report_failure("ack fired on a channel with no request");
				w = find_way(ph_addr[ch]);
				assert (w >= 0) else
					report_failure("ack fired for a line that the model does not hold");
				assert (rd_resp[ch].data == m_data[ph_addr[ch][OFFSET_W +: INDEX_W]][w]) else
					report_failure($sformatf("ERROR rd_resp[%0d].data got %h expected %h", ch,
						rd_resp[ch].data, m_data[ph_addr[ch][OFFSET_W +: INDEX_W]][w]));
				assert (pred_hit[ch] || filled[ch]) else
					report_failure("a read of an absent line was acked without a fill");
				active[ch] = 1'b0;
			end
		end
	endtask

	// covers one clock cycle and notes the transfers just before the rising edge
	// then checks outputs and drives the responder on the falling edge
	task automatic tick();
		logic [31:0] r;
		#1;
		fill_go   = fill.valid & fill_ready;
		wr_go     = wr.valid & wr_ready;
		miss_go   = miss.valid & miss_ready;
		held      = miss.valid & ~miss_ready;
		held_addr = miss.addr.word;
		@(negedge wclk);
		cyc++;
		if (cyc > CYCLE_LIMIT) begin
			report_failure("timeout: the run went past its cycle limit");
		end
		// a channel keeps its request up through the edge that takes its ack
		for (int ch = 0; ch < NUM_CH; ch++) begin
			if (!active[ch]) begin
				rd_req[ch].valid = 1'b0;
			end
		end
		r = next_rand();
		if (miss_go) begin
			fq_addr.push_back(held_addr);
			fq_due.push_back(cyc + 1 + int'(r[31:16] % 16'd6));
		end
		if (fill_go) begin
			model_fill(fill.addr.word, fill.data);
			for (int ch = 0; ch < NUM_CH; ch++) begin
				if (active[ch] && (line_of(ph_addr[ch]) == fill.addr.word)) begin
					filled[ch] = 1'b1;
				end
			end
			void'(fq_addr.pop_front());
			void'(fq_due.pop_front());
			fill.valid = 1'b0;
		end
		if (wr_go) begin
			model_write(wr);
			wr.valid = 1'b0;
		end
		check_miss();
		check_acks();
		miss_ready = (r[1:0] != 2'd0);
		if (!fill.valid && (fq_addr.size() > 0) && (cyc >= fq_due[0])) begin
			fill.valid     = 1'b1;
			fill.addr.word = fq_addr[0];
			fill.data      = backing_line(fq_addr[0]);
		end
	endtask

	// ====================
	// operations
	// ====================

	task automatic read_phase();
		logic [31:0] r;
		r = next_rand();
		used[0] = (r[1:0] != 2'd1);
		used[1] = (r[1:0] != 2'd0);
		for (int ch = 0; ch < NUM_CH; ch++) begin
			active[ch] = 1'b0;
			filled[ch] = 1'b0;
			if (used[ch]) begin
				ph_addr[ch]      = pick_addr();
				pred_hit[ch]     = (find_way(ph_addr[ch]) >= 0);
				active[ch]       = 1'b1;
				rd_req[ch].valid = 1'b1;
				rd_req[ch].addr.word = ph_addr[ch];
			end else begin
				pred_hit[ch] = 1'b1;
			end
		end
		expect_nomiss = pred_hit[0] && pred_hit[1];
		// both channels miss on the same cycle, so channel 0 must go out first
		check_prio = used[0] && used[1] && !pred_hit[0] && !pred_hit[1]
			&& (line_of(ph_addr[0]) != line_of(ph_addr[1]));
		first_seen = 1'b0;
		while (active[0] || active[1]) begin
			tick();
		end
	endtask

	task automatic write_op();
		logic [31:0] r;
		r = next_rand();
		wr.valid     = 1'b1;
		wr.addr.word = pick_addr();
		wr.data      = {next_rand(), next_rand()};
		wr.sel       = r[7:0];
		wr.inv       = (r[10:8] == 3'd0);
		while (wr.valid) begin
			tick();
		end
	endtask

	// wait until no miss, fill or write is left anywhere
	task automatic drain();
		int calm;
		calm = 0;
		while (calm < 3) begin
			tick();
			if (!miss.valid && (fq_addr.size() == 0) && !fill.valid && fill_ready && wr_ready) begin
				calm++;
			end else begin
				calm = 0;
			end
		end
	endtask

	initial begin
		seed       = 32'd38013;
		cyc        = 0;
		wclk       = 1'b0;
		rst        = 1'b1;
		rd_req     = '0;
		wr         = '0;
		fill       = '0;
		miss_ready = 1'b0;
		held       = 1'b0;
		held_addr  = '0;
		expect_nomiss = 1'b1;
		check_prio = 1'b0;
		first_seen = 1'b0;
		for (int ch = 0; ch < NUM_CH; ch++) begin
			active[ch]   = 1'b0;
			used[ch]     = 1'b0;
			pred_hit[ch] = 1'b1;
			filled[ch]   = 1'b0;
			ph_addr[ch]  = '0;
		end
		for (int s = 0; s < SETS; s++) begin
			for (int w = 0; w < WAYS; w++) begin
				m_valid[s][w] = 1'b0;
				m_tag[s][w]   = '0;
				m_data[s][w]  = '0;
			end
		end
		repeat (5) @(negedge wclk);
		rst = 1'b0;

		// idle outputs right after reset
		for (int i = 0; i < 5; i++) begin
			tick();
			assert (!rd_resp[0].ack && !rd_resp[1].ack && !miss.valid) else
				report_failure("ack or miss valid is high after reset");
			assert (wr_ready && fill_ready) else
				report_failure("wr_ready or fill_ready is low after reset");
		end

		for (int op = 0; op < NUM_OPS; op++) begin
			if (next_rand() % 32'd8 < 32'd5) begin
				read_phase();
			end else begin
				write_op();
			end
			drain();
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- sources.f
common/cache_pkg.sv
design/lookup/set_ram.sv
design/lookup/tag_compare.sv
design/miss_arbiter.sv
design/line_writer.sv
design/cache_top.sv
tb/tb_cache.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_cache -o tb_cache

# the simulator exit status is not trusted, the log decides
./obj_dir/tb_cache > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: PASSED" sim.log; then
	exit 0
else
	exit 1
fi
